/* rtl/core_pkg.sv */
// pipeline core constants
// datapath widths, ALU operation codes and the nop word
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // ALU operation codes, decode to execute
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd7;

    // all-zero word, decodes to no register or memory write
    localparam logic [XLEN-1:0] NOP_WORD = '0;

endpackage

/* rtl/isa_pkg.sv */
// MIPS subset ISA definitions
// instruction word views, opcodes and function codes
package isa_pkg;

    // one instruction word, read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    // function codes for R-type
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

/* rtl/fetch_unit.sv */
// fetch stage
// program counter, next-PC select and instruction memory with load port
`timescale 1ns/1ns

module fetch_unit
    import core_pkg::*;
#(
    parameter  int IMEM_DEPTH = 64,
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH)
)
(
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               core_run,
    input  logic               imem_write_en,
    input  logic [IMEM_AW-1:0] imem_write_addr,   // word index
    input  logic [XLEN-1:0]    imem_write_data,
    input  logic               branch_taken,
    input  logic [XLEN-1:0]    branch_target,
    output logic [XLEN-1:0]    fetch_instr,
    output logic [XLEN-1:0]    fetch_pc
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] imem [IMEM_DEPTH];

    always_comb
    begin
        if (!core_run)
            pc_next = pc;                 // stopped, hold
        else if (branch_taken)
            pc_next = branch_target;      // redirect after the delay slot
        else
            pc_next = pc + XLEN'(4);
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else
            pc <= pc_next;
    end

    // load port, usable at any time
    always_ff @(posedge SYS_clk)
    begin
        if (imem_write_en)
            imem[imem_write_addr] <= imem_write_data;
    end

    // asynchronous read, nops while stopped
    assign fetch_instr = core_run ? imem[pc[IMEM_AW+1:2]] : NOP_WORD;
    assign fetch_pc    = pc;

endmodule

/* rtl/decode_unit.sv */
// decode stage
// IF/ID register, control decode, register file and branch resolution
`timescale 1ns/1ns

module decode_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [XLEN-1:0]       fetch_instr,
    input  logic [XLEN-1:0]       fetch_pc,
    input  logic                  wb_write_en,
    input  logic [REG_ADDR_W-1:0] wb_write_reg,
    input  logic [XLEN-1:0]       wb_write_data,
    output logic                  branch_taken,
    output logic [XLEN-1:0]       branch_target,
    output logic [REG_ADDR_W-1:0] rs_num,
    output logic [REG_ADDR_W-1:0] rt_num,
    output logic [REG_ADDR_W-1:0] dest_reg,
    output logic [XLEN-1:0]       rs_value,
    output logic [XLEN-1:0]       rt_value,
    output logic [XLEN-1:0]       imm_ext,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  alu_src_imm,
    output logic [ALU_OP_W-1:0]   alu_op
);

    instr_u          id_word;                 // IF/ID instruction
    logic [XLEN-1:0] id_pc;
    logic [XLEN-1:0] regs [NUM_REGS];
    logic            writes_reg;
    logic            is_beq;
    logic            is_bne;
    logic            rs_eq_rt;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            id_word <= NOP_WORD;
            id_pc   <= '0;
        end
        else
        begin
            id_word <= fetch_instr;
            id_pc   <= fetch_pc;
        end
    end

    // register file, $0 is never written
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb_write_en && wb_write_reg != '0)
            regs[wb_write_reg] <= wb_write_data;
    end

    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] num);
        if (num == '0)
            return '0;
        else if (wb_write_en && wb_write_reg == num)
            return wb_write_data;                 // write-through
        else
            return regs[num];
    endfunction

    always_comb
    begin
        writes_reg  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        alu_op      = ALU_ADD;
        dest_reg    = id_word.i.rt;               // I-type writes rt
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        case (id_word.r.opcode)
            OP_RTYPE:
            begin
                dest_reg   = id_word.r.rd;
                writes_reg = 1'b1;
                case (id_word.r.funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: writes_reg = 1'b0;   // outside the subset
                endcase
            end
            OP_ADDI:
            begin
                writes_reg  = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                writes_reg  = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

    always_comb
    begin
        rs_value = read_reg(rs_num);
        rt_value = read_reg(rt_num);
    end

    assign reg_write = writes_reg && (dest_reg != '0);
    assign rs_num    = id_word.i.rs;
    assign rt_num    = id_word.i.rt;
    assign imm_ext   = {{(XLEN-16){id_word.i.imm[15]}}, id_word.i.imm};

    // branch compare in decode, one delay slot
    assign rs_eq_rt      = (rs_value == rt_value);
    assign branch_taken  = (is_beq && rs_eq_rt) || (is_bne && !rs_eq_rt);
    assign branch_target = id_pc + XLEN'(4) + {imm_ext[XLEN-3:0], 2'b00};

endmodule

/* rtl/execute_unit.sv */
// execute stage
// ID/EX register, operand forwarding and ALU
`timescale 1ns/1ns

module execute_unit
    import core_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [REG_ADDR_W-1:0] rs_num,
    input  logic [REG_ADDR_W-1:0] rt_num,
    input  logic [XLEN-1:0]       rs_value,
    input  logic [XLEN-1:0]       rt_value,
    input  logic [XLEN-1:0]       imm_ext,
    input  logic [REG_ADDR_W-1:0] dest_reg,
    input  logic                  reg_write,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  alu_src_imm,
    input  logic [ALU_OP_W-1:0]   alu_op,
    input  logic                  mem_fwd_en,
    input  logic [REG_ADDR_W-1:0] mem_fwd_reg,
    input  logic [XLEN-1:0]       mem_fwd_data,
    input  logic                  wb_write_en,
    input  logic [REG_ADDR_W-1:0] wb_write_reg,
    input  logic [XLEN-1:0]       wb_write_data,
    output logic [XLEN-1:0]       ex_result,
    output logic [XLEN-1:0]       ex_store_data,
    output logic [REG_ADDR_W-1:0] ex_dest_reg,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write
);

    logic [REG_ADDR_W-1:0] ex_rs_num;
    logic [REG_ADDR_W-1:0] ex_rt_num;
    logic [XLEN-1:0]       ex_rs_value;
    logic [XLEN-1:0]       ex_rt_value;
    logic [XLEN-1:0]       ex_imm;
    logic                  ex_alu_src_imm;
    logic [ALU_OP_W-1:0]   ex_alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       rt_fwd;

    // ID/EX control
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_rs_num      <= '0;
            ex_rt_num      <= '0;
            ex_dest_reg    <= '0;
            ex_reg_write   <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_alu_src_imm <= 1'b0;
            ex_alu_op      <= ALU_ADD;
        end
        else
        begin
            ex_rs_num      <= rs_num;
            ex_rt_num      <= rt_num;
            ex_dest_reg    <= dest_reg;
            ex_reg_write   <= reg_write;
            ex_mem_read    <= mem_read;
            ex_mem_write   <= mem_write;
            ex_alu_src_imm <= alu_src_imm;
            ex_alu_op      <= alu_op;
        end
    end

    // ID/EX payload
    always_ff @(posedge SYS_clk)
    begin
        ex_rs_value <= rs_value;
        ex_rt_value <= rt_value;
        ex_imm      <= imm_ext;
    end

    // memory stage wins over write-back
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] num,
        input logic [XLEN-1:0]       reg_value
    );
        if (mem_fwd_en && mem_fwd_reg == num)
            return mem_fwd_data;
        else if (wb_write_en && wb_write_reg == num)
            return wb_write_data;
        else
            return reg_value;
    endfunction

    always_comb
    begin
        op_a   = pick_operand(ex_rs_num, ex_rs_value);
        rt_fwd = pick_operand(ex_rt_num, ex_rt_value);
        op_b   = ex_alu_src_imm ? ex_imm : rt_fwd;
    end

    always_comb
    begin
        case (ex_alu_op)
            ALU_ADD: ex_result = op_a + op_b;
            ALU_SUB: ex_result = op_a - op_b;
            ALU_AND: ex_result = op_a & op_b;
            ALU_OR:  ex_result = op_a | op_b;
            ALU_SLT: ex_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: ex_result = '0;
        endcase
    end

    assign ex_store_data = rt_fwd;               // sw data, forwarded like rt

endmodule

/* rtl/mem_wb_unit.sv */
// memory and write-back stages
// EX/MEM register, data memory, MEM/WB register and result select
`timescale 1ns/1ns

module mem_wb_unit
    import core_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
)
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [XLEN-1:0]       ex_result,
    input  logic [XLEN-1:0]       ex_store_data,
    input  logic [REG_ADDR_W-1:0] ex_dest_reg,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    output logic                  mem_fwd_en,
    output logic [REG_ADDR_W-1:0] mem_fwd_reg,
    output logic [XLEN-1:0]       mem_fwd_data,
    output logic                  wb_write_en,
    output logic [REG_ADDR_W-1:0] wb_write_reg,
    output logic [XLEN-1:0]       wb_write_data
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]       mm_result;
    logic [XLEN-1:0]       mm_store_data;
    logic [REG_ADDR_W-1:0] mm_dest_reg;
    logic                  mm_reg_write;
    logic                  mm_mem_read;
    logic                  mm_mem_write;
    logic [XLEN-1:0]       dmem [DMEM_DEPTH];
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       wb_load_data;
    logic [XLEN-1:0]       wb_alu_result;
    logic                  wb_is_load;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mm_dest_reg  <= '0;
            mm_reg_write <= 1'b0;
            mm_mem_read  <= 1'b0;
            mm_mem_write <= 1'b0;
            wb_write_reg <= '0;
            wb_write_en  <= 1'b0;
            wb_is_load   <= 1'b0;
        end
        else
        begin
            mm_dest_reg  <= ex_dest_reg;
            mm_reg_write <= ex_reg_write;
            mm_mem_read  <= ex_mem_read;
            mm_mem_write <= ex_mem_write;
            wb_write_reg <= mm_dest_reg;
            wb_write_en  <= mm_reg_write;
            wb_is_load   <= mm_mem_read;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mm_result     <= ex_result;
        mm_store_data <= ex_store_data;
        wb_load_data  <= load_data;
        wb_alu_result <= mm_result;
        if (mm_mem_write)
            dmem[mm_result[DMEM_AW-1:0]] <= mm_store_data;   // result is a word address
    end

    assign load_data = dmem[mm_result[DMEM_AW-1:0]];

    // a load's address is not its result, so no forwarding from here
    assign mem_fwd_en    = mm_reg_write && !mm_mem_read;
    assign mem_fwd_reg   = mm_dest_reg;
    assign mem_fwd_data  = mm_result;
    assign wb_write_data = wb_is_load ? wb_load_data : wb_alu_result;

endmodule

/* rtl/mips_pipeline.sv */
// five-stage MIPS subset pipeline, top level
// fetch, decode, execute and memory/write-back wired together
`timescale 1ns/1ns

module mips_pipeline #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
)
(
    input  logic                          SYS_clk,
    input  logic                          SYS_reset,
    input  logic                          core_run,
    input  logic                          imem_write_en,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_write_addr,
    input  logic [31:0]                   imem_write_data,
    output logic                          wb_write_en,
    output logic [4:0]                    wb_write_reg,
    output logic [31:0]                   wb_write_data
);

    logic [31:0] fetch_instr;
    logic [31:0] fetch_pc;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [4:0]  rs_num;
    logic [4:0]  rt_num;
    logic [4:0]  dest_reg;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] imm_ext;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        alu_src_imm;
    logic [3:0]  alu_op;
    logic [31:0] ex_result;
    logic [31:0] ex_store_data;
    logic [4:0]  ex_dest_reg;
    logic        ex_reg_write;
    logic        ex_mem_read;
    logic        ex_mem_write;
    logic        mem_fwd_en;
    logic [4:0]  mem_fwd_reg;
    logic [31:0] mem_fwd_data;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .SYS_clk         (SYS_clk),
        .SYS_reset       (SYS_reset),
        .core_run        (core_run),
        .imem_write_en   (imem_write_en),
        .imem_write_addr (imem_write_addr),
        .imem_write_data (imem_write_data),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .fetch_instr     (fetch_instr),
        .fetch_pc        (fetch_pc)
    );

    decode_unit u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .fetch_instr   (fetch_instr),
        .fetch_pc      (fetch_pc),
        .wb_write_en   (wb_write_en),      // register file write port
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .rs_num        (rs_num),
        .rt_num        (rt_num),
        .dest_reg      (dest_reg),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .imm_ext       (imm_ext),
        .reg_write     (reg_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_src_imm   (alu_src_imm),
        .alu_op        (alu_op)
    );

    execute_unit u_execute (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .rs_num        (rs_num),
        .rt_num        (rt_num),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .imm_ext       (imm_ext),
        .dest_reg      (dest_reg),
        .reg_write     (reg_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_src_imm   (alu_src_imm),
        .alu_op        (alu_op),
        .mem_fwd_en    (mem_fwd_en),
        .mem_fwd_reg   (mem_fwd_reg),
        .mem_fwd_data  (mem_fwd_data),
        .wb_write_en   (wb_write_en),      // write-back forwarding
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_dest_reg   (ex_dest_reg),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write)
    );

    mem_wb_unit #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem_wb (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_dest_reg   (ex_dest_reg),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .mem_fwd_en    (mem_fwd_en),
        .mem_fwd_reg   (mem_fwd_reg),
        .mem_fwd_data  (mem_fwd_data),
        .wb_write_en   (wb_write_en),
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data)
    );

endmodule

/* bench/mips_pipeline_assertions.sv */
// write-back port checks for the pipeline top level
// attached to mips_pipeline by bind from the testbench
`timescale 1ns/1ns

module mips_pipeline_assertions
    import core_pkg::*;
(
    input logic                  SYS_clk,
    input logic                  SYS_reset,
    input logic                  wb_write_en,
    input logic [REG_ADDR_W-1:0] wb_write_reg,
    input logic [XLEN-1:0]       wb_write_data
);

    int failures = 0;                             // failed assertion count

    // $0 is never a write-back target
    no_reg0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_write_en |-> wb_write_reg != '0)
    else
    begin
        $error("write-back strobe with destination register 0");
        failures++;
    end

    reset_clears_strobe: assert property (@(posedge SYS_clk)
        SYS_reset |=> !wb_write_en)
    else
    begin
        $error("write-back strobe high one cycle after reset");
        failures++;
    end

    no_unknown_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_write_en |-> !$isunknown({wb_write_reg, wb_write_data}))
    else
    begin
        $error("write-back register or data unknown while strobe is high");
        failures++;
    end

endmodule

/* bench/tb_mips_pipeline.sv */
// testbench for the five-stage MIPS subset pipeline
// loads a program table, runs it and checks every write-back in order
`timescale 1ns/1ns

module tb_mips_pipeline
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int WB_TIMEOUT = 20;              // cycles allowed per write-back

    logic                  SYS_clk;
    logic                  SYS_reset;
    logic                  core_run;
    logic                  imem_write_en;
    logic [IMEM_AW-1:0]    imem_write_addr;
    logic [XLEN-1:0]       imem_write_data;
    logic                  wb_write_en;
    logic [REG_ADDR_W-1:0] wb_write_reg;
    logic [XLEN-1:0]       wb_write_data;

    // program table with one row per instruction word
    logic [XLEN-1:0]       prog_word [$];
    bit                    prog_wb   [$];
    logic [REG_ADDR_W-1:0] prog_reg  [$];
    logic [XLEN-1:0]       prog_val  [$];

    mips_pipeline u_dut (
        .SYS_clk         (SYS_clk),
        .SYS_reset       (SYS_reset),
        .core_run        (core_run),
        .imem_write_en   (imem_write_en),
        .imem_write_addr (imem_write_addr),
        .imem_write_data (imem_write_data),
        .wb_write_en     (wb_write_en),
        .wb_write_reg    (wb_write_reg),
        .wb_write_data   (wb_write_data)
    );

    bind mips_pipeline mips_pipeline_assertions u_assertions (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .wb_write_en   (wb_write_en),
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data)
    );

    always #4 SYS_clk = ~SYS_clk;                 // 8 ns period

    function automatic logic [XLEN-1:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        instr_u w;
        w          = '0;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        instr_u w;
        w          = '0;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic add_row(input logic [XLEN-1:0] word, input bit wb,
                           input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] val);
        prog_word.push_back(word);
        prog_wb.push_back(wb);
        prog_reg.push_back(rd);
        prog_val.push_back(val);
    endtask

    task automatic build_program();
        add_row(i_word(OP_ADDI, 5'd1, 5'd0, 16'h0f0f), 1'b1, 5'd1, 32'h0000_0f0f);   // addi r1
        add_row(i_word(OP_ADDI, 5'd2, 5'd0, 16'hff00), 1'b1, 5'd2, 32'hffff_ff00);   // -256
        add_row(r_word(FN_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h0000_0e0f);        // dist 1 and 2
        add_row(r_word(FN_SUB, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hffff_ff00);
        add_row(r_word(FN_AND, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'h0000_0f00);
        add_row(r_word(FN_OR, 5'd6, 5'd5, 5'd3), 1'b1, 5'd6, 32'h0000_0f0f);
        add_row(r_word(FN_SLT, 5'd7, 5'd4, 5'd5), 1'b1, 5'd7, 32'h0000_0001);        // -256 < 3840
        add_row(r_word(FN_SLT, 5'd8, 5'd6, 5'd4), 1'b1, 5'd8, 32'h0000_0000);
        add_row(i_word(OP_ADDI, 5'd9, 5'd6, 16'hfff0), 1'b1, 5'd9, 32'h0000_0eff);   // r6 - 16
        add_row(r_word(FN_ADD, 5'd0, 5'd1, 5'd2), 1'b0, 5'd0, 32'h0);                // to $0
        add_row(r_word(FN_ADD, 5'd10, 5'd0, 5'd9), 1'b1, 5'd10, 32'h0000_0eff);      // $0 reads 0
        add_row(i_word(OP_ADDI, 5'd0, 5'd1, 16'h0007), 1'b0, 5'd0, 32'h0);
        add_row(i_word(OP_SW, 5'd6, 5'd0, 16'h0004), 1'b0, 5'd0, 32'h0);             // mem[4] = r6
        add_row(i_word(OP_ADDI, 5'd11, 5'd0, 16'h0002), 1'b1, 5'd11, 32'h0000_0002);
        add_row(i_word(OP_LW, 5'd12, 5'd11, 16'h0002), 1'b1, 5'd12, 32'h0000_0f0f);  // mem[4]
        add_row(i_word(OP_SW, 5'd10, 5'd0, 16'h0005), 1'b0, 5'd0, 32'h0);            // mem[5] = r10
        add_row(r_word(FN_ADD, 5'd13, 5'd12, 5'd1), 1'b1, 5'd13, 32'h0000_1e1e);     // load data fwd
        add_row(i_word(OP_LW, 5'd14, 5'd0, 16'h0005), 1'b1, 5'd14, 32'h0000_0eff);
        add_row(i_word(OP_ADDI, 5'd15, 5'd0, 16'h0001), 1'b1, 5'd15, 32'h0000_0001);
        add_row(i_word(OP_ADDI, 5'd16, 5'd0, 16'h0002), 1'b1, 5'd16, 32'h0000_0002);
        add_row(r_word(FN_ADD, 5'd17, 5'd14, 5'd15), 1'b1, 5'd17, 32'h0000_0f00);
        add_row(i_word(OP_BEQ, 5'd12, 5'd1, 16'h0002), 1'b0, 5'd0, 32'h0);           // taken
        add_row(i_word(OP_ADDI, 5'd18, 5'd0, 16'h0055), 1'b1, 5'd18, 32'h0000_0055); // delay slot
        add_row(i_word(OP_ADDI, 5'd19, 5'd0, 16'h0066), 1'b0, 5'd0, 32'h0);          // skipped
        add_row(i_word(OP_BNE, 5'd12, 5'd1, 16'h0002), 1'b0, 5'd0, 32'h0);           // not taken
        add_row(i_word(OP_ADDI, 5'd20, 5'd0, 16'hffff), 1'b1, 5'd20, 32'hffff_ffff); // delay slot
        add_row(i_word(OP_ADDI, 5'd21, 5'd20, 16'h0003), 1'b1, 5'd21, 32'h0000_0002);
        add_row(r_word(FN_SUB, 5'd22, 5'd17, 5'd16), 1'b1, 5'd22, 32'h0000_0efe);
    endtask

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic timed_out(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_write(input int row,
                               input logic [REG_ADDR_W-1:0] got_reg,
                               input logic [XLEN-1:0]       got_data,
                               input logic [REG_ADDR_W-1:0] exp_reg,
                               input logic [XLEN-1:0]       exp_data);
        if (got_reg !== exp_reg || got_data !== exp_data)
            mismatch($sformatf("row %0d wrote r%0d = %h, expected r%0d = %h",
                               row, got_reg, got_data, exp_reg, exp_data));
    endtask

    task automatic check_quiet(input string phase, input logic got_en,
                               input logic [REG_ADDR_W-1:0] got_reg,
                               input logic [XLEN-1:0]       got_data);
        if (got_en !== 1'b0)
            mismatch($sformatf("unexpected write-back strobe (%b) during %s, r%0d = %h",
                               got_en, phase, got_reg, got_data));
    endtask

    task automatic quiet_cycles(input int n, input string phase);
        repeat (n)
        begin
            @(negedge SYS_clk);
            check_quiet(phase, wb_write_en, wb_write_reg, wb_write_data);
        end
    endtask

    // loads every instruction word through the load port
    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            @(posedge SYS_clk);
            #1;
            imem_write_en   = 1'b1;
            imem_write_addr = IMEM_AW'(i);
            if (i < prog_word.size())
                imem_write_data = prog_word[i];
            else
                imem_write_data = i_word(OP_ADDI, 5'd0, 5'd0, 16'(i));   // writes only $0
            @(negedge SYS_clk);
            check_quiet("program load", wb_write_en, wb_write_reg, wb_write_data);
        end
        @(posedge SYS_clk);
        #1;
        imem_write_en = 1'b0;
    endtask

    task automatic wait_write_back(input int row);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WB_TIMEOUT)
        begin
            @(negedge SYS_clk);
            seen = (wb_write_en === 1'b1);
            waited++;
        end
        if (!seen)
            timed_out($sformatf("timeout: the write-back of table row %0d to r%0d never came",
                                row, prog_reg[row]));
        else
            check_write(row, wb_write_reg, wb_write_data, prog_reg[row], prog_val[row]);
    endtask

    initial
    begin
        SYS_clk         = 1'b0;
        SYS_reset       = 1'b1;
        core_run        = 1'b0;
        imem_write_en   = 1'b0;
        imem_write_addr = '0;
        imem_write_data = '0;
        build_program();

        quiet_cycles(7, "reset");
        @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;                         // after the 8th edge

        load_program();
        quiet_cycles(4, "idle before run");
        @(posedge SYS_clk);
        #1;
        core_run = 1'b1;

        for (int row = 0; row < prog_word.size(); row++)
        begin
            if (prog_wb[row])
                wait_write_back(row);
        end

        quiet_cycles(16, "drain");

        if (u_dut.u_assertions.failures == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures on the write-back port",
                     u_dut.u_assertions.failures);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* files.f */
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/mips_pipeline.sv
bench/mips_pipeline_assertions.sv
bench/tb_mips_pipeline.sv

/* run.sh */
#!/bin/sh
# build the pipeline testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips_pipeline -f files.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
